/* hdl/video_capture_pkg.sv */
`default_nettype none

package video_capture_pkg;

    //////////////////////////////////////////////////////////////
    // console frame geometry

    // free-running raw frame
    localparam int raw_width  = 1716;
    localparam int raw_height = 525;

    // last raw line index of each known format
    localparam int lines_240p = 262;
    localparam int lines_480  = 524;
    localparam int lines_pal  = 624;

    // visible window, direct and line-doubled
    localparam int win_hstart         = 265;
    localparam int win_vstart         = 40;
    localparam int win_height         = 480;
    localparam int win_hstart_dbl     = 249;
    localparam int win_vstart_dbl     = 18;
    localparam int win_height_dbl     = 504;
    localparam int win_vstart_dbl_pal = 19;
    localparam int win_height_dbl_pal = 600;
    localparam int win_width          = 720;

    // colour bars
    localparam int bars_offset = 40;
    localparam int bar_width   = 80;

    //////////////////////////////////////////////////////////////
    // types

    // first word of a pixel: red and top of green
    typedef struct packed {
        logic [7:0] red;
        logic [3:0] green_hi;
    } bus_first_t;

    // second word: bottom of green and blue
    typedef struct packed {
        logic [3:0] green_lo;
        logic [7:0] blue;
    } bus_second_t;

    typedef union packed {
        bus_first_t  first;
        bus_second_t second;
    } bus_word_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [11:0] raw_x;
        logic [11:0] raw_y;
    } raw_pos_t;

    typedef struct packed {
        logic add_line;
        logic is_pal;
        logic resync;
    } frame_format_t;

    typedef struct packed {
        logic [11:0] pixel_x;
        logic [11:0] pixel_y;
    } pixel_pos_t;

endpackage

`default_nettype wire

/* hdl/raw_timing.sv */
`default_nettype none

module raw_timing import video_capture_pkg::*; #(
    parameter int unsigned idle_limit = 1000
) (
    input  logic          clock,
    input  logic          reset,
    input  bus_word_t     indata,
    input  logic          hsync_n,
    input  logic          vsync_n,
    input  logic          generate_timing,
    output raw_pos_t      raw_pos,
    output frame_format_t format,
    output logic          force_generate,
    output logic          phase
);

    localparam int count_width = $clog2(idle_limit + 1);

    logic                   hsync_q;
    logic                   vsync_q;
    logic                   hsync_fall;
    logic                   vsync_fall;
    logic                   free_run;
    logic                   idle;
    logic [count_width-1:0] idle_count;
    frame_format_t          next_format;

    assign hsync_fall = hsync_q && !hsync_n;
    assign vsync_fall = vsync_q && !vsync_n;
    assign free_run   = force_generate || generate_timing;

    // console idle: no syncs and all data pins pulled up
    assign idle = hsync_n && vsync_n && (&indata);

    // second word of each pixel sits on odd raw positions
    assign phase = raw_pos.raw_x[0];

    // classify the frame that just ended by its last line
    always_comb begin
        next_format.add_line = raw_pos.raw_y == 12'(lines_240p);
        next_format.is_pal   = raw_pos.raw_y == 12'(lines_pal);
        next_format.resync   = !(raw_pos.raw_y == 12'(lines_240p)
                              || raw_pos.raw_y == 12'(lines_480)
                              || raw_pos.raw_y == 12'(lines_pal));
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hsync_q        <= 1'b1;
            vsync_q        <= 1'b1;
            raw_pos        <= '0;
            format         <= '{add_line: 1'b0, is_pal: 1'b0, resync: 1'b1};
            force_generate <= 1'b0;
            idle_count     <= '0;
        end else begin
            hsync_q <= hsync_n;
            vsync_q <= vsync_n;

            if (free_run) begin
                // own 1716 x 525 timing
                if (raw_pos.raw_x == 12'(raw_width - 1)) begin
                    raw_pos.raw_x <= '0;
                    if (raw_pos.raw_y == 12'(raw_height - 1)) begin
                        raw_pos.raw_y <= '0;
                        format.resync <= 1'b0;
                    end else begin
                        raw_pos.raw_y <= raw_pos.raw_y + 12'd1;
                    end
                end else begin
                    raw_pos.raw_x <= raw_pos.raw_x + 12'd1;
                end
            end else if (hsync_fall) begin
                raw_pos.raw_x <= '0;
                if (vsync_fall) begin
                    raw_pos.raw_y <= '0;
                    format        <= next_format;
                end else begin
                    raw_pos.raw_y <= raw_pos.raw_y + 12'd1;
                end
            end else begin
                raw_pos.raw_x <= raw_pos.raw_x + 12'd1;
            end

            // idle timeout, sticky until reset
            if (!force_generate) begin
                if (idle) begin
                    if (idle_count == count_width'(idle_limit - 1)) begin
                        force_generate <= 1'b1;
                        format.resync  <= 1'b1;
                    end else begin
                        idle_count <= idle_count + 1'b1;
                    end
                end else begin
                    idle_count <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/visible_window.sv */
`default_nettype none

module visible_window import video_capture_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  raw_pos_t      raw_pos,
    input  frame_format_t format,
    input  logic          phase,
    input  logic          line_doubler,
    input  logic [7:0]    conf240p,
    output pixel_pos_t    pixel_pos,
    output logic          de,
    output logic          frame_start
);

    logic [11:0] hstart;
    logic [11:0] vstart;
    logic [11:0] height;
    logic        line_start;
    logic        first_line;
    pixel_pos_t  next_pos;

    // window for the current format
    always_comb begin
        if (!line_doubler) begin
            hstart = 12'(win_hstart);
            vstart = 12'(win_vstart);
            height = 12'(win_height);
        end else if (format.is_pal) begin
            hstart = 12'(win_hstart_dbl);
            vstart = 12'(win_vstart_dbl_pal);
            height = 12'(win_height_dbl_pal);
        end else begin
            hstart = 12'(win_hstart_dbl);
            vstart = 12'(win_vstart_dbl);
            height = 12'(win_height_dbl);
        end
        // 240p picture can be nudged sideways
        if (format.add_line) begin
            hstart = hstart + {4'd0, conf240p};
        end
    end

    assign line_start = raw_pos.raw_x == hstart;
    assign first_line = raw_pos.raw_y == vstart;

    always_comb begin
        next_pos = pixel_pos;
        if (line_start) begin
            next_pos.pixel_x = '0;
            next_pos.pixel_y = first_line ? 12'd0 : pixel_pos.pixel_y + 12'd1;
        end else begin
            // one pixel per word pair
            next_pos.pixel_x = pixel_pos.pixel_x + {11'd0, phase};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pixel_pos   <= '0;
            de          <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            pixel_pos   <= next_pos;
            de          <= next_pos.pixel_x < 12'(win_width) && next_pos.pixel_y < height;
            frame_start <= line_start && first_line;
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_assembler.sv */
`default_nettype none

module pixel_assembler import video_capture_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  bus_word_t  indata,
    input  logic       phase,
    input  pixel_pos_t pixel_pos,
    input  logic       de,
    input  logic       generate_video,
    input  logic       force_generate,
    output rgb_t       rgb
);

    localparam logic [7:0] full = 8'd255;

    bus_word_t   first_word;
    logic [11:0] bar_x;
    logic [2:0]  bar_index;
    logic        in_bars;
    rgb_t        bar_rgb;
    rgb_t        joined;

    //////////////////////////////////////////////////////////////
    // colour bars

    assign bar_x     = pixel_pos.pixel_x - 12'(bars_offset);
    assign in_bars   = pixel_pos.pixel_x >= 12'(bars_offset) && bar_x < 12'(8 * bar_width);
    assign bar_index = 3'(bar_x / 12'(bar_width));

    always_comb begin
        bar_rgb = '0;
        if (in_bars) begin
            case (bar_index)
                3'd0: bar_rgb.red = full;
                3'd1: bar_rgb.green = full;
                3'd2: bar_rgb.blue = full;
                3'd3: bar_rgb = '{red: full, green: full, blue: full};
                3'd5: bar_rgb = '{red: 8'd0, green: full, blue: full};
                3'd6: bar_rgb = '{red: full, green: full, blue: 8'd0};
                3'd7: bar_rgb = '{red: full, green: 8'd0, blue: full};
                // bar 4 stays black
                default: bar_rgb = '0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////
    // captured pixels

    // red and upper green from the held word, the rest from this one
    assign joined = '{
        red:   first_word.first.red,
        green: {first_word.first.green_hi, indata.second.green_lo},
        blue:  indata.second.blue
    };

    always_ff @(posedge clock) begin
        if (!phase) begin
            first_word <= indata;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rgb <= '0;
        end else if (!de) begin
            rgb <= '0;
        end else if (generate_video || force_generate) begin
            rgb <= bar_rgb;
        end else if (phase) begin
            rgb <= joined;
        end
    end

endmodule

`default_nettype wire

/* hdl/pin_short_check.sv */
`default_nettype none

module pin_short_check import video_capture_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  bus_word_t   indata,
    input  logic        de,
    input  logic        frame_start,
    output logic [21:0] pin_ok
);

    logic [11:0] word;
    logic [10:0] seen_hl;
    logic [10:0] seen_lh;
    logic [10:0] sample_hl;
    logic [10:0] sample_lh;

    assign word = indata;

    // upper pin of each pair against the one below it
    always_comb begin
        for (int i = 0; i < 11; i++) begin
            sample_hl[i] = de && word[i+1] && !word[i];
            sample_lh[i] = de && !word[i+1] && word[i];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seen_hl <= '0;
            seen_lh <= '0;
            pin_ok  <= '0;
        end else if (frame_start) begin
            pin_ok  <= {seen_hl, seen_lh};
            seen_hl <= sample_hl;
            seen_lh <= sample_lh;
        end else begin
            seen_hl <= seen_hl | sample_hl;
            seen_lh <= seen_lh | sample_lh;
        end
    end

endmodule

`default_nettype wire

/* hdl/video_capture.sv */
`default_nettype none

module video_capture import video_capture_pkg::*; #(
    parameter int unsigned idle_limit = 1000
) (
    input  logic          clock,
    input  logic          reset,
    input  bus_word_t     indata,
    input  logic          hsync_n,
    input  logic          vsync_n,
    input  logic          line_doubler,
    input  logic          generate_video,
    input  logic          generate_timing,
    input  logic [7:0]    conf240p,
    output rgb_t          rgb,
    output logic          de,
    output pixel_pos_t    pixel_pos,
    output frame_format_t format,
    output logic          force_generate,
    output logic [21:0]   pin_ok
);

    raw_pos_t   raw_pos;
    logic       phase;
    pixel_pos_t win_pos;
    logic       win_de;
    logic       frame_start;

    raw_timing #(
        .idle_limit (idle_limit)
    ) i_raw_timing (
        .clock           (clock),
        .reset           (reset),
        .indata          (indata),
        .hsync_n         (hsync_n),
        .vsync_n         (vsync_n),
        .generate_timing (generate_timing),
        .raw_pos         (raw_pos),
        .format          (format),
        .force_generate  (force_generate),
        .phase           (phase)
    );

    visible_window i_visible_window (
        .clock        (clock),
        .reset        (reset),
        .raw_pos      (raw_pos),
        .format       (format),
        .phase        (phase),
        .line_doubler (line_doubler),
        .conf240p     (conf240p),
        .pixel_pos    (win_pos),
        .de           (win_de),
        .frame_start  (frame_start)
    );

    pixel_assembler i_pixel_assembler (
        .clock          (clock),
        .reset          (reset),
        .indata         (indata),
        .phase          (phase),
        .pixel_pos      (win_pos),
        .de             (win_de),
        .generate_video (generate_video),
        .force_generate (force_generate),
        .rgb            (rgb)
    );

    pin_short_check i_pin_short_check (
        .clock       (clock),
        .reset       (reset),
        .indata      (indata),
        .de          (win_de),
        .frame_start (frame_start),
        .pin_ok      (pin_ok)
    );

    // window position and enable, aligned with the registered colour
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            de        <= 1'b0;
            pixel_pos <= '0;
        end else begin
            de        <= win_de;
            pixel_pos <= win_pos;
        end
    end

endmodule

`default_nettype wire

/* sim/video_capture_props.sv */
`default_nettype none

module video_capture_props import video_capture_pkg::*; #(
    parameter int unsigned idle_limit = 1000
) (
    input  logic          clock,
    input  logic          reset,
    input  bus_word_t     indata,
    input  logic          hsync_n,
    input  logic          vsync_n,
    input  logic          generate_video,
    input  logic          generate_timing,
    input  logic          phase,
    input  logic          win_de,
    input  logic          frame_start,
    input  rgb_t          rgb,
    input  logic          de,
    input  pixel_pos_t    pixel_pos,
    input  frame_format_t format,
    input  logic          force_generate,
    input  logic [21:0]   pin_ok
);

    timeunit 1ns;
    timeprecision 100ps;

    // red, green, blue, white, black, cyan, yellow, magenta
    localparam logic [23:0] bar_table [8] = '{
        24'hff0000, 24'h00ff00, 24'h0000ff, 24'hffffff,
        24'h000000, 24'h00ffff, 24'hffff00, 24'hff00ff
    };
    localparam int          bar_px      = 80;
    localparam logic [50:0] reset_state = {3'b001, 48'd0};

    int unsigned   fail_count = 0;

    logic          hsync_q;
    logic          vsync_q;
    logic          line_fall;
    logic          sync_fall;
    logic [11:0]   line_count;
    frame_format_t format_exp;
    bus_word_t     word_q;
    bus_word_t     word_qq;
    rgb_t          joined_exp;
    rgb_t          bar_exp;
    int unsigned   idle_run;
    logic          de_q;
    logic          de_rise;
    int unsigned   since_rise;
    logic          forced_rise;
    logic [11:0]   rise_y;
    logic [10:0]   pair_hl;
    logic [10:0]   pair_lh;
    logic [10:0]   acc_hl;
    logic [10:0]   acc_lh;
    logic [21:0]   pin_exp;
    logic [50:0]   out_state;

    // frame type from the last raw line of the frame
    function automatic frame_format_t classify(input logic [11:0] last_line);
        frame_format_t f;
        f.add_line = last_line == 12'(lines_240p);
        f.is_pal   = last_line == 12'(lines_pal);
        f.resync   = last_line != 12'(lines_240p) && last_line != 12'(lines_480)
                     && last_line != 12'(lines_pal);
        return f;
    endfunction

    function automatic rgb_t bar_colour(input logic [11:0] x);
        rgb_t c;
        c = '0;
        if (x >= 12'(bars_offset) && x < 12'(bars_offset + 8 * bar_px)) begin
            c = bar_table[(int'(x) - bars_offset) / bar_px];
        end
        return c;
    endfunction

    assign line_fall  = hsync_q && !hsync_n;
    assign sync_fall  = line_fall && vsync_q && !vsync_n;
    assign de_rise    = de && !de_q;
    assign bar_exp    = bar_colour(pixel_pos.pixel_x);
    assign out_state  = {format, force_generate, de, rgb, pin_ok};
    assign joined_exp = '{
        red:   word_qq.first.red,
        green: {word_qq.first.green_hi, word_q.second.green_lo},
        blue:  word_q.second.blue
    };

    // adjacent pins at opposite levels while the window is open
    always_comb begin
        for (int i = 0; i < 11; i++) begin
            pair_hl[i] = win_de && indata[i+1] && !indata[i];
            pair_lh[i] = win_de && !indata[i+1] && indata[i];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hsync_q     <= 1'b1;
            vsync_q     <= 1'b1;
            line_count  <= '0;
            format_exp  <= '0;
            word_q      <= '0;
            word_qq     <= '0;
            idle_run    <= 0;
            de_q        <= 1'b0;
            since_rise  <= 0;
            forced_rise <= 1'b0;
            rise_y      <= '0;
            acc_hl      <= '0;
            acc_lh      <= '0;
            pin_exp     <= '0;
        end else begin
            hsync_q    <= hsync_n;
            vsync_q    <= vsync_n;
            // lines seen on the sync inputs since the last frame start
            if (sync_fall) begin
                line_count <= '0;
                format_exp <= classify(line_count);
            end else if (line_fall) begin
                line_count <= line_count + 12'd1;
            end
            word_q     <= indata;
            word_qq    <= word_q;
            idle_run   <= (hsync_n && vsync_n && (&indata)) ? idle_run + 1 : 0;
            de_q       <= de;
            since_rise <= de_rise ? 1 : since_rise + 1;
            if (de_rise) begin
                forced_rise <= force_generate;
                rise_y      <= pixel_pos.pixel_y;
            end
            if (frame_start) begin
                pin_exp <= {acc_hl, acc_lh};
                acc_hl  <= pair_hl;
                acc_lh  <= pair_lh;
            end else begin
                acc_hl <= acc_hl | pair_hl;
                acc_lh <= acc_lh | pair_lh;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // checks

    assert property (@(posedge clock) $fell(reset) |-> out_state == reset_state)
    else begin
        $error("ERR %0t reset state expected %h got %h", $time, reset_state,
               $sampled(out_state));
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        sync_fall && !force_generate && !generate_timing |=> format == format_exp)
    else begin
        $error("ERR %0t format expected %b got %b", $time, $sampled(format_exp),
               $sampled(format));
        fail_count++;
    end

    // second word of a pair in capture mode
    assert property (@(posedge clock) disable iff (reset)
        de && $past(phase) && !$past(phase, 2) && !$past(generate_video)
        && !$past(force_generate) |-> rgb == joined_exp)
    else begin
        $error("ERR %0t rgb expected %h got %h", $time, $sampled(joined_exp), $sampled(rgb));
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset) !de |-> rgb == '0)
    else begin
        $error("ERR %0t rgb expected %h got %h", $time, 24'd0, $sampled(rgb));
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        de && ($past(generate_video) || $past(force_generate)) |-> rgb == bar_exp)
    else begin
        $error("ERR %0t rgb expected %h got %h", $time, $sampled(bar_exp), $sampled(rgb));
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset) force_generate |=> force_generate)
    else begin
        $error("generated timing dropped back to the input timing at %0t", $time);
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        $rose(force_generate) |-> idle_run == idle_limit)
    else begin
        $error("ERR %0t idle_run expected %0d got %0d", $time, idle_limit, $sampled(idle_run));
        fail_count++;
    end

    // consecutive lines of the generated timing
    assert property (@(posedge clock) disable iff (reset)
        de_rise && force_generate && forced_rise && pixel_pos.pixel_y == rise_y + 12'd1
        |-> since_rise == raw_width)
    else begin
        $error("ERR %0t line_clocks expected %0d got %0d", $time, raw_width,
               $sampled(since_rise));
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset) frame_start |=> pin_ok == pin_exp)
    else begin
        $error("ERR %0t pin_ok expected %h got %h", $time, $sampled(pin_exp), $sampled(pin_ok));
        fail_count++;
    end

endmodule

bind video_capture video_capture_props #(
    .idle_limit (idle_limit)
) i_video_capture_props (
    .clock           (clock),
    .reset           (reset),
    .indata          (indata),
    .hsync_n         (hsync_n),
    .vsync_n         (vsync_n),
    .generate_video  (generate_video),
    .generate_timing (generate_timing),
    .phase           (phase),
    .win_de          (win_de),
    .frame_start     (frame_start),
    .rgb             (rgb),
    .de              (de),
    .pixel_pos       (pixel_pos),
    .format          (format),
    .force_generate  (force_generate),
    .pin_ok          (pin_ok)
);

`default_nettype wire

/* sim/video_capture_tb.sv */
`default_nettype none

module video_capture_tb import video_capture_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned idle_limit  = 200;
    localparam int          period      = 4;
    localparam int          sync_width  = 16;
    localparam int          frame_count = 7;
    localparam int          free_lines  = 6;

    // last raw line, clocks per line, colour bars and data mask of each frame
    localparam int          frame_last [frame_count] = '{262, 624, 300, 60, 60, 60, 60};
    localparam int          frame_len  [frame_count] = '{200, 200, 200, 1000, 1000, 1000, 1000};
    localparam logic        frame_bars [frame_count] = '{0, 0, 0, 0, 1, 0, 0};
    localparam logic [11:0] frame_mask [frame_count] = '{
        12'hfff, 12'hfff, 12'hfff, 12'hfff, 12'hfff, 12'h0f0, 12'h0f0
    };

    logic          clock;
    logic          reset;
    bus_word_t     indata;
    logic          hsync_n;
    logic          vsync_n;
    logic          line_doubler;
    logic          generate_video;
    logic          generate_timing;
    logic [7:0]    conf240p;
    rgb_t          rgb;
    logic          de;
    pixel_pos_t    pixel_pos;
    frame_format_t format;
    logic          force_generate;
    logic [21:0]   pin_ok;
    logic [31:0]   lcg_state;
    int unsigned   other_errors;
    int unsigned   assertion_errors;

    video_capture #(
        .idle_limit (idle_limit)
    ) i_video_capture (
        .clock           (clock),
        .reset           (reset),
        .indata          (indata),
        .hsync_n         (hsync_n),
        .vsync_n         (vsync_n),
        .line_doubler    (line_doubler),
        .generate_video  (generate_video),
        .generate_timing (generate_timing),
        .conf240p        (conf240p),
        .rgb             (rgb),
        .de              (de),
        .pixel_pos       (pixel_pos),
        .format          (format),
        .force_generate  (force_generate),
        .pin_ok          (pin_ok)
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    function automatic logic [11:0] next_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[27:16];
    endfunction

    function automatic longint planned_cycles();
        longint total;
        total = 0;
        for (int f = 0; f < frame_count; f++) begin
            total += longint'(frame_last[f] + 1) * frame_len[f];
        end
        return total + idle_limit + free_lines * raw_width;
    endfunction

    //////////////////////////////////////////////////////////////
    // console-like stimulus

    // vsync falls together with hsync on the first line of a frame
    task automatic drive_line(input bit first, input int len, input logic [11:0] mask);
        for (int c = 0; c < len; c++) begin
            @(posedge clock);
            hsync_n <= c >= sync_width;
            vsync_n <= !(first && c < sync_width);
            indata  <= next_word() & mask;
        end
    endtask

    task automatic drive_frame(input int f);
        @(posedge clock);
        generate_video <= frame_bars[f];
        for (int l = 0; l <= frame_last[f]; l++) begin
            drive_line(l == 0, frame_len[f], frame_mask[f]);
        end
    endtask

    // no syncs and all pins pulled up until the fallback timing takes over
    task automatic go_idle();
        int waited;
        @(posedge clock);
        hsync_n        <= 1'b1;
        vsync_n        <= 1'b1;
        indata         <= '1;
        generate_video <= 1'b0;
        waited = 0;
        while (!force_generate && waited < idle_limit + 10) begin
            @(negedge clock);
            waited++;
        end
        if (!force_generate) begin
            $display("idle input did not switch to generated timing");
            other_errors++;
        end
    endtask

    task automatic wait_lines(input int count);
        int   rises;
        int   waited;
        logic de_prev;
        rises   = 0;
        waited  = 0;
        de_prev = de;
        while (rises < count && waited < (count + 2) * raw_width) begin
            @(negedge clock);
            if (de && !de_prev) begin
                rises++;
            end
            de_prev = de;
            waited++;
        end
        if (rises < count) begin
            $display("data enable stopped rising under generated timing");
            other_errors++;
        end
    endtask

    initial begin : watchdog
        #(planned_cycles() * period * 6 / 5);
        $display("simulation timed out before the test sequence finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        lcg_state       = 32'd86236;
        other_errors    = 0;
        reset           = 1'b1;
        indata          = '0;
        hsync_n         = 1'b1;
        vsync_n         = 1'b1;
        line_doubler    = 1'b0;
        generate_video  = 1'b0;
        generate_timing = 1'b0;
        conf240p        = 8'd8;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        for (int f = 0; f < frame_count; f++) begin
            drive_frame(f);
        end
        go_idle();
        // pins active again while the fallback timing has to hold
        @(posedge clock);
        indata <= 12'h5a5;
        wait_lines(4);
        repeat (4) @(posedge clock);

        assertion_errors = i_video_capture.i_video_capture_props.fail_count;
        $display("assertion failures %0d, other errors %0d", assertion_errors, other_errors);
        if (assertion_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/video_capture_pkg.sv
hdl/raw_timing.sv
hdl/visible_window.sv
hdl/pixel_assembler.sv
hdl/pin_short_check.sv
hdl/video_capture.sv
sim/video_capture_props.sv
sim/video_capture_tb.sv

/* Bender.yml */
package:
  name: video_capture

sources:
  - hdl/video_capture_pkg.sv
  - hdl/raw_timing.sv
  - hdl/visible_window.sv
  - hdl/pixel_assembler.sv
  - hdl/pin_short_check.sv
  - hdl/video_capture.sv
  - target: simulation
    files:
      - sim/video_capture_props.sv
      - sim/video_capture_tb.sv
